/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_TEXT ?= Simulation PASSED

SOURCES := $(wildcard source/*.sv source/*.svh bench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_tb;

	import isa_pkg::*;
	import machine_pkg::*;

	localparam int CLOCK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_INSTR = 12;
	localparam int NUM_TESTS = 8;
	localparam int WAIT_MARGIN = 64; // Input waits and loop passes
	localparam int TIMEOUT_CYCLES =
		NUM_TESTS * (MAX_INSTR * 4 + RESET_CYCLES + MAX_INSTR + WAIT_MARGIN);
	localparam int IMEM_AW = $clog2(`CPU_IMEM_DEPTH);
	localparam int LOOP_COUNT = 5;
	localparam int INPUT_DELAY = 2; // Waiting cycles before the strobe

	typedef enum {END_DONE, END_UNKNOWN, END_FAULT} end_kind_t;

	logic               clock, reset_n, run, input_strobe, load_enable;
	word_t              switches, out_value;
	logic [IMEM_AW-1:0] load_address;
	instruction_t       load_instruction;
	logic               running, done, input_waiting, unknown_opcode, stack_fault;

	// Stimulus table with one row per test
	string        test_name [NUM_TESTS];
	instruction_t program_words [NUM_TESTS][MAX_INSTR];
	word_t        switch_value [NUM_TESTS];
	word_t        expected_out [NUM_TESTS];
	end_kind_t    expected_end [NUM_TESTS];

	int          entry_count, current, emit_slot;
	int          error_count, pass_count;
	int unsigned lcg_state = 25;

	cpu_top DUT (
		.clock(clock), .reset_n(reset_n), .run(run), .switches(switches),
		.input_strobe(input_strobe), .load_enable(load_enable), .load_address(load_address),
		.load_instruction(load_instruction), .out_value(out_value), .running(running),
		.done(done), .input_waiting(input_waiting), .unknown_opcode(unknown_opcode),
		.stack_fault(stack_fault)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(TIMEOUT_CYCLES * CLOCK_PERIOD);
		$display("Watchdog expired after %0d cycles, a program never reached its end",
			TIMEOUT_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	function automatic word_t next_switch_value();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return word_t'(lcg_state[30:15]); // Upper bits are the better ones
	endfunction

	task automatic begin_entry(string name, word_t sw, word_t out, end_kind_t ending);
		int i;
		current = entry_count;
		entry_count++;
		test_name[current] = name;
		switch_value[current] = sw;
		expected_out[current] = out;
		expected_end[current] = ending;
		emit_slot = 0;
		for (i = 0; i < MAX_INSTR; i++) begin
			program_words[current][i] = '0; // EOF padding
		end
	endtask

	task automatic emit(logic [7:0] op, int a, int b, int c);
		program_words[current][emit_slot] = {op, 8'(a), 8'(b), 8'(c)};
		emit_slot++;
	endtask

	task automatic load_literal(int value, int dest);
		emit(OP_LITERAL, (value >> 8) & 'hFF, value & 'hFF, dest);
	endtask

	task automatic build_table();
		word_t drawn;
		entry_count = 0;
		begin_entry("arithmetic", '0,
			word_t'((300 + 250) * (300 + 250) + 1 + (250 - 300) - 1), END_DONE);
		load_literal(300, 1);
		load_literal(250, 2);
		emit(OP_ADD, 1, 2, 3);
		emit(OP_SUB, 2, 1, 4);
		emit(OP_MUL, 3, 3, 5);     // Wraps past 16 bits
		emit(OP_INC, 5, 0, 0);
		emit(OP_DEC, 4, 0, 0);
		emit(OP_MOV, 5, 6, 0);
		emit(OP_ADD, 6, 4, 7);
		emit(OP_OUTPUT, 7, 0, 0);
		emit(OP_EOF, 0, 0, 0);
		// Truth values packed as decimal digits
		begin_entry("logic", '0, word_t'((int'(0 == 0) * 10 + int'(5 != 0 || 0 != 0)) * 10
			+ int'(5 != 0 && 10 != 0)), END_DONE);
		load_literal(5, 1);
		load_literal(0, 2);
		load_literal(10, 9);
		emit(OP_NOT, 2, 3, 0);
		emit(OP_OR, 1, 2, 4);
		emit(OP_AND, 1, 9, 5);
		emit(OP_MUL, 3, 9, 3);
		emit(OP_ADD, 3, 4, 3);
		emit(OP_MUL, 3, 9, 3);
		emit(OP_ADD, 3, 5, 3);
		emit(OP_OUTPUT, 3, 0, 0);
		emit(OP_EOF, 0, 0, 0);
		begin_entry("compare", '0, word_t'((int'(-3 == 4) * 10 + int'(-3 < 4)) * 10
			+ int'(4 > -3)), END_DONE);
		load_literal('hFFFD, 1);   // -3 for the signed compares
		load_literal(4, 2);
		load_literal(10, 9);
		emit(OP_EQ, 1, 2, 3);
		emit(OP_LT, 1, 2, 4);
		emit(OP_GT, 2, 1, 5);
		emit(OP_MUL, 3, 9, 3);
		emit(OP_ADD, 3, 4, 3);
		emit(OP_MUL, 3, 9, 3);
		emit(OP_ADD, 3, 5, 3);
		emit(OP_OUTPUT, 3, 0, 0);
		emit(OP_EOF, 0, 0, 0);
		begin_entry("countdown loop", '0, word_t'(LOOP_COUNT), END_DONE);
		load_literal(LOOP_COUNT, 1);
		load_literal(0, 2);
		load_literal(9, 3);        // Exit address
		emit(OP_BRANCH, 1, 0, 0);  // Address 3
		emit(OP_JUMP, 0, 0, 6);
		emit(OP_JUMP, 1, 3, 0);
		emit(OP_DEC, 1, 0, 0);
		emit(OP_INC, 2, 0, 0);
		emit(OP_JUMP, 0, 0, 3);
		emit(OP_OUTPUT, 2, 0, 0);
		emit(OP_EOF, 0, 0, 0);
		begin_entry("stack save and restore", '0, word_t'('h1234), END_DONE);
		emit(OP_STACK, 0, 16, 0);
		load_literal('h1234, 1);
		emit(OP_STORE, 1, 0, 3);   // Address 13
		load_literal(0, 1);
		emit(OP_LOAD, 0, 3, 1);
		emit(OP_OUTPUT, 1, 0, 0);
		emit(OP_EOF, 0, 0, 0);
		drawn = next_switch_value();
		begin_entry("input", drawn, word_t'(drawn + 16'sd1), END_DONE);
		emit(OP_INPUT, 2, 0, 0);
		emit(OP_INC, 2, 0, 0);
		emit(OP_OUTPUT, 2, 0, 0);
		emit(OP_EOF, 0, 0, 0);
		begin_entry("unknown opcode", '0, word_t'(77), END_UNKNOWN);
		load_literal(77, 1);
		emit(OP_OUTPUT, 1, 0, 0);
		emit(8'd9, 0, 0, 0);       // Old divide slot
		load_literal(99, 1);
		emit(OP_OUTPUT, 1, 0, 0);
		emit(OP_EOF, 0, 0, 0);
		begin_entry("stack fault", '0, word_t'(42), END_FAULT);
		load_literal(42, 1);
		emit(OP_OUTPUT, 1, 0, 0);
		emit(OP_STACK, `CPU_STACK_DEPTH >> 8, `CPU_STACK_DEPTH & 'hFF, 0);
		emit(OP_LOAD, 0, 0, 2);    // One past the last stack word
		emit(OP_OUTPUT, 2, 0, 0);
		emit(OP_EOF, 0, 0, 0);
	endtask

	task automatic check_word(string what, word_t actual, word_t expected);
		if (actual !== expected) begin
			error_count++;
			$display("Fail at time %0t: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic check_flag(string what, logic actual, logic expected);
		if (actual !== expected) begin
			error_count++;
			$display("Fail at time %0t: %s is %b, expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic reset_and_load(int t);
		int i;
		@(negedge clock);
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clock);
		reset_n = 1'b1;
		for (i = 0; i < MAX_INSTR; i++) begin
			load_enable = 1'b1;
			load_address = IMEM_AW'(i);
			load_instruction = program_words[t][i];
			@(negedge clock);
		end
		load_enable = 1'b0;
	endtask

	task automatic run_entry(int t);
		int errors_before;
		int wait_cycles;
		errors_before = error_count;
		wait_cycles = 0;
		switches = '0;
		reset_and_load(t);
		run = 1'b1;
		@(negedge clock);
		run = 1'b0;
		while (!(done || unknown_opcode || stack_fault)) begin
			if (input_waiting && !input_strobe) begin
				wait_cycles++;
				if (wait_cycles > INPUT_DELAY) begin
					switches = switch_value[t];
					input_strobe = 1'b1; // Rising edge ends INPUT
					wait_cycles = 0;
				end
			end else begin
				input_strobe = 1'b0;
			end
			@(negedge clock);
		end
		input_strobe = 1'b0;
		check_word({test_name[t], " out_value"}, out_value, expected_out[t]);
		check_flag({test_name[t], " done"}, done, expected_end[t] == END_DONE);
		check_flag({test_name[t], " unknown_opcode"}, unknown_opcode,
			expected_end[t] == END_UNKNOWN);
		check_flag({test_name[t], " stack_fault"}, stack_fault, expected_end[t] == END_FAULT);
		check_flag({test_name[t], " running"}, running, 1'b0);
		check_flag({test_name[t], " input_waiting"}, input_waiting, 1'b0);
		if (error_count == errors_before) begin
			pass_count++;
			$display("test %s: ok", test_name[t]);
		end else begin
			$display("test %s: %0d check(s) wrong", test_name[t], error_count - errors_before);
		end
	endtask

	initial begin
		reset_n = 1'b0;
		run = 1'b0;
		switches = '0;
		input_strobe = 1'b0;
		load_enable = 1'b0;
		load_address = '0;
		load_instruction = '0;
		error_count = 0;
		pass_count = 0;
		build_table();
		for (int t = 0; t < entry_count; t++) begin
			run_entry(t);
		end
		$display("Tests run: %0d, passed: %0d, with errors: %0d, wrong checks: %0d",
			entry_count, pass_count, entry_count - pass_count, error_count);
		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+source
source/isa_pkg.sv
source/machine_pkg.sv
source/sync_ram.sv
source/register_file.sv
source/alu.sv
source/control_unit.sv
source/cpu_top.sv
bench/cpu_tb.sv

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
	input  isa_pkg::opcode_t   opcode,
	input  machine_pkg::word_t operand_a,
	input  machine_pkg::word_t operand_b,
	output machine_pkg::word_t result
);

	import isa_pkg::*;
	import machine_pkg::*;

	always_comb begin
		case (opcode)
			OP_ADD: begin
				result = operand_a + operand_b;
			end
			OP_SUB: begin
				result = operand_a - operand_b;
			end
			OP_MUL: begin
				result = operand_a * operand_b; // Low 16 bits kept
			end
			OP_INC: begin
				result = operand_a + 16'sd1;
			end
			OP_DEC: begin
				result = operand_a - 16'sd1;
			end
			OP_MOV: begin
				result = operand_a;
			end
			// Truth results are 0 or 1
			OP_NOT: begin
				result = word_t'(operand_a == '0);
			end
			OP_OR: begin
				result = word_t'((operand_a != '0) || (operand_b != '0));
			end
			OP_AND: begin
				result = word_t'((operand_a != '0) && (operand_b != '0));
			end
			OP_EQ: begin
				result = word_t'(operand_a == operand_b);
			end
			OP_LT: begin
				result = word_t'(operand_a < operand_b); // Signed operands
			end
			OP_GT: begin
				result = word_t'(operand_a > operand_b);
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

/* source/control_unit.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module control_unit (
	input  logic                    clock,
	input  logic                    reset_n,
	input  logic                    run,
	input  logic                    input_strobe,
	input  machine_pkg::word_t      switches,
	output machine_pkg::pc_t        fetch_address,
	input  isa_pkg::instruction_t   fetched,
	output machine_pkg::reg_index_t index_a,
	output machine_pkg::reg_index_t index_b,
	output machine_pkg::reg_index_t index_c,
	input  machine_pkg::word_t      read_a,
	input  machine_pkg::word_t      read_b,
	input  machine_pkg::word_t      alu_result,
	output isa_pkg::opcode_t        opcode,
	output logic                    reg_write_enable,
	output machine_pkg::reg_index_t reg_write_index,
	output machine_pkg::word_t      reg_write_value,
	output machine_pkg::stack_addr_t stack_address,
	output logic                    stack_write_enable,
	output machine_pkg::word_t      stack_write_data,
	input  machine_pkg::word_t      stack_read_data,
	output machine_pkg::word_t      out_value,
	output logic                    running,
	output logic                    done,
	output logic                    input_waiting,
	output logic                    unknown_opcode,
	output logic                    stack_fault
);

	import isa_pkg::*;
	import machine_pkg::*;

	cpu_state_t   state;
	instruction_t instruction;
	pc_t          pc;
	pc_t          sp;
	pc_t          stack_target;
	logic         stack_out_of_range;
	logic         strobe_q;
	logic         strobe_rise;

	assign fetch_address = pc;
	assign opcode = instruction.opcode;
	assign index_a = instruction.a[3:0];
	assign index_b = instruction.b[3:0];
	assign index_c = instruction.c[3:0];

	assign strobe_rise = input_strobe & ~strobe_q;

	// STORE offset is {b,c}, LOAD offset is {a,b}
	assign stack_target = (instruction.opcode == OP_STORE) ?
		sp - {instruction.b, instruction.c} : sp - {instruction.a, instruction.b};
	assign stack_out_of_range = stack_target > pc_t'(`CPU_STACK_LIMIT);
	assign stack_address = stack_addr_t'(stack_target);
	assign stack_write_data = read_a;
	assign stack_write_enable = (state == EXECUTE) && (instruction.opcode == OP_STORE) &&
		!stack_out_of_range;

	assign running = (state != IDLE) && (state != HALTED);
	assign input_waiting = (state == EXECUTE) && (instruction.opcode == OP_INPUT);

	always_ff @(posedge clock) begin
		if (state == LATCH) begin
			instruction <= fetched;
		end
	end

	// Register write side
	always_comb begin
		reg_write_enable = 1'b0;
		reg_write_index = instruction.c[3:0];
		reg_write_value = alu_result;
		if (state == STACK_WAIT) begin
			reg_write_enable = (instruction.opcode == OP_LOAD);
			reg_write_value = stack_read_data;
		end else if (state == EXECUTE) begin
			case (instruction.opcode)
				OP_LITERAL: begin
					reg_write_enable = 1'b1;
					reg_write_value = {instruction.a, instruction.b};
				end
				OP_INPUT: begin
					reg_write_enable = strobe_rise;
					reg_write_index = instruction.a[3:0];
					reg_write_value = switches;
				end
				OP_ADD, OP_SUB, OP_MUL, OP_OR, OP_AND, OP_EQ, OP_LT, OP_GT: begin
					reg_write_enable = 1'b1;
				end
				OP_INC, OP_DEC: begin
					reg_write_enable = 1'b1;
					reg_write_index = instruction.a[3:0];
				end
				OP_MOV, OP_NOT: begin
					reg_write_enable = 1'b1;
					reg_write_index = instruction.b[3:0];
				end
				default: begin
					reg_write_enable = 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			state <= IDLE;
			pc <= '0;
			sp <= '0;
			out_value <= '0;
			strobe_q <= 1'b0;
			done <= 1'b0;
			unknown_opcode <= 1'b0;
			stack_fault <= 1'b0;
		end else begin
			strobe_q <= input_strobe;
			case (state)
				IDLE: begin
					if (run) state <= FETCH;
				end
				FETCH: state <= LATCH;
				LATCH: state <= EXECUTE;
				EXECUTE: begin
					// Most opcodes step to the next word
					pc <= pc + 16'd1;
					state <= FETCH;
					case (instruction.opcode)
						OP_EOF: begin
							pc <= pc;
							done <= 1'b1;
							state <= HALTED;
						end
						OP_LOAD, OP_STORE: begin
							pc <= pc;
							if (stack_out_of_range) begin
								stack_fault <= 1'b1;
								state <= HALTED;
							end else begin
								state <= STACK_WAIT;
							end
						end
						OP_INPUT: begin
							if (!strobe_rise) begin
								pc <= pc; // Hold until the strobe edge
								state <= EXECUTE;
							end
						end
						OP_OUTPUT: out_value <= read_a;
						OP_BRANCH: begin
							if (read_a == '0) pc <= pc + 16'd2; // Skip next
						end
						OP_JUMP: begin
							if (instruction.a == '0) begin
								pc <= {instruction.b, instruction.c};
							end else begin
								pc <= pc_t'(read_b);
							end
						end
						OP_STACK: sp <= sp + {instruction.a, instruction.b};
						OP_LITERAL, OP_ADD, OP_SUB, OP_MUL, OP_INC, OP_DEC, OP_MOV,
						OP_NOT, OP_OR, OP_AND, OP_EQ, OP_LT, OP_GT: begin
							state <= FETCH; // Result written by the write side
						end
						default: begin
							pc <= pc;
							unknown_opcode <= 1'b1;
							state <= HALTED;
						end
					endcase
				end
				STACK_WAIT: begin
					pc <= pc + 16'd1;
					state <= FETCH;
				end
				default: state <= HALTED; // Only reset leaves
			endcase
		end
	end

endmodule

/* source/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Instruction memory words, one 32-bit instruction each
`define CPU_IMEM_DEPTH 256

// Stack memory words
`define CPU_STACK_DEPTH 2048

// Highest legal stack address
// A LOAD or STORE beyond it halts with a fault
`define CPU_STACK_LIMIT (`CPU_STACK_DEPTH - 1)

// Registers addressed by the low nibble of an operand
`define CPU_REG_COUNT 16

`endif

/* source/cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_top (
	input  logic                                 clock,
	input  logic                                 reset_n,
	input  logic                                 run,
	input  machine_pkg::word_t                   switches,
	input  logic                                 input_strobe,
	input  logic                                 load_enable,
	input  logic [$clog2(`CPU_IMEM_DEPTH)-1:0]   load_address,
	input  isa_pkg::instruction_t                load_instruction,
	output machine_pkg::word_t                   out_value,
	output logic                                 running,
	output logic                                 done,
	output logic                                 input_waiting,
	output logic                                 unknown_opcode,
	output logic                                 stack_fault
);

	import isa_pkg::*;
	import machine_pkg::*;

	localparam int IMEM_AW = $clog2(`CPU_IMEM_DEPTH);

	pc_t               fetch_address;
	logic [IMEM_AW-1:0] imem_address;
	instruction_t      fetched;
	reg_index_t        index_a, index_b, index_c;
	word_t             read_a, read_b;
	opcode_t           opcode;
	word_t             alu_result;
	logic              reg_write_enable;
	reg_index_t        reg_write_index;
	word_t             reg_write_value;
	stack_addr_t       stack_address;
	logic              stack_write_enable;
	word_t             stack_write_data, stack_read_data;

	// Loader owns the instruction RAM while it writes
	assign imem_address = load_enable ? load_address : fetch_address[IMEM_AW-1:0];

	sync_ram #(.payload_t(instruction_t), .DEPTH(`CPU_IMEM_DEPTH)) instruction_memory (
		.clock(clock), .write_enable(load_enable), .address(imem_address),
		.write_data(load_instruction), .read_data(fetched)
	);

	sync_ram #(.payload_t(word_t), .DEPTH(`CPU_STACK_DEPTH)) stack_memory (
		.clock(clock), .write_enable(stack_write_enable), .address(stack_address),
		.write_data(stack_write_data), .read_data(stack_read_data)
	);

	register_file registers (
		.clock(clock), .write_enable(reg_write_enable), .write_index(reg_write_index),
		.write_value(reg_write_value), .index_a(index_a), .index_b(index_b),
		.index_c(index_c), .read_a(read_a), .read_b(read_b), .read_c()
	);

	alu math (.opcode(opcode), .operand_a(read_a), .operand_b(read_b), .result(alu_result));

	control_unit control (
		.clock(clock), .reset_n(reset_n), .run(run), .input_strobe(input_strobe),
		.switches(switches), .fetch_address(fetch_address), .fetched(fetched),
		.index_a(index_a), .index_b(index_b), .index_c(index_c),
		.read_a(read_a), .read_b(read_b), .alu_result(alu_result), .opcode(opcode),
		.reg_write_enable(reg_write_enable), .reg_write_index(reg_write_index),
		.reg_write_value(reg_write_value), .stack_address(stack_address),
		.stack_write_enable(stack_write_enable), .stack_write_data(stack_write_data),
		.stack_read_data(stack_read_data), .out_value(out_value), .running(running),
		.done(done), .input_waiting(input_waiting), .unknown_opcode(unknown_opcode),
		.stack_fault(stack_fault)
	);

endmodule

/* source/isa_pkg.sv */
package isa_pkg;

	// Values missing from the list are rejected as unknown
	typedef enum logic [7:0] {
		OP_EOF     = 8'd0,
		OP_LOAD    = 8'd1,  // <offset hi> <offset lo> <dest>
		OP_STORE   = 8'd2,  // <src> <offset hi> <offset lo>
		OP_LITERAL = 8'd3,
		OP_INPUT   = 8'd4,
		OP_OUTPUT  = 8'd5,
		OP_ADD     = 8'd6,
		OP_SUB     = 8'd7,
		OP_MUL     = 8'd8,
		OP_BRANCH  = 8'd11,
		OP_JUMP    = 8'd12,
		OP_STACK   = 8'd13,
		OP_INC     = 8'd23,
		OP_DEC     = 8'd24,
		OP_MOV     = 8'd25,
		OP_NOT     = 8'd26,
		OP_OR      = 8'd27,
		OP_AND     = 8'd28,
		OP_EQ      = 8'd29,
		OP_LT      = 8'd30,
		OP_GT      = 8'd31
	} opcode_t;

	typedef logic [7:0] operand_t;

	// Opcode in the top byte
	typedef struct packed {
		opcode_t  opcode;
		operand_t a;
		operand_t b;
		operand_t c;
	} instruction_t;

endpackage

/* source/machine_pkg.sv */
package machine_pkg;

	// Registers and stack hold signed words
	typedef logic signed [15:0] word_t;

	// Shared by the program counter and the stack pointer
	typedef logic [15:0] pc_t;

	typedef logic [3:0] reg_index_t;

	typedef logic [10:0] stack_addr_t;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,      // pc on the instruction RAM
		LATCH,      // RAM data into the instruction register
		EXECUTE,
		STACK_WAIT, // Stack RAM read latency
		HALTED
	} cpu_state_t;

endpackage

/* source/register_file.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module register_file (
	input  logic                    clock,
	input  logic                    write_enable,
	input  machine_pkg::reg_index_t write_index,
	input  machine_pkg::word_t      write_value,
	input  machine_pkg::reg_index_t index_a,
	input  machine_pkg::reg_index_t index_b,
	input  machine_pkg::reg_index_t index_c,
	output machine_pkg::word_t      read_a,
	output machine_pkg::word_t      read_b,
	output machine_pkg::word_t      read_c
);

	import machine_pkg::*;

	word_t registers [`CPU_REG_COUNT];

	always_ff @(posedge clock) begin
		if (write_enable) begin
			registers[write_index] <= write_value;
		end
	end

	// Combinational reads for the execute cycle
	assign read_a = registers[index_a];
	assign read_b = registers[index_b];
	assign read_c = registers[index_c];

endmodule

/* source/sync_ram.sv */
`timescale 1ns/1ps

module sync_ram #(
	parameter type payload_t = logic [15:0],
	parameter int DEPTH = 256
) (
	input  logic                     clock,
	input  logic                     write_enable,
	input  logic [$clog2(DEPTH)-1:0] address,
	input  payload_t                 write_data,
	output payload_t                 read_data
);

	payload_t memory [DEPTH];

	// One clock of read latency, old data on a write
	always_ff @(posedge clock) begin
		if (write_enable) begin
			memory[address] <= write_data;
		end
		read_data <= memory[address];
	end

endmodule
